/* tb.f */
+incdir+hdl
hdl/iigs_bus_pkg.sv
hdl/iigs_dev_pkg.sv
hdl/bus_port.sv
hdl/io_regs.sv
hdl/adb_glu.sv
hdl/prtc.sv
hdl/iigs_io.sv
sim/tb_iigs_io.sv

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary -j 0 -f tb.f --top-module tb_iigs_io -Mdir obj_dir; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_iigs_io)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -q "All tests passed"; then
  exit 0
fi
exit 1

/* sim/tb_iigs_io.sv */
`timescale 1ns/1ps

module tb_iigs_io
  import iigs_bus_pkg::*;
  import iigs_dev_pkg::*;
();

  localparam int CLK_PERIOD        = 40;
  // worst case bus access incl. memory delay and handshake release
  localparam int CYCLES_PER_ACCESS = 16;
  localparam int ACCESS_BUDGET     = 150;
  localparam int TIMEOUT_CYCLES    = ACCESS_BUDGET * CYCLES_PER_ACCESS + 50;

  logic    clk_sys;
  logic    cpu_vda;
  logic    req;
  logic    we;
  bank_t   bank;
  addr_t   addr;
  data_t   wdata;
  logic    ack;
  data_t   rdata;
  logic    mem_req;
  logic    mem_we;
  bank_t   mem_bank;
  addr_t   mem_addr;
  data_t   mem_wdata;
  logic    mem_ack;
  data_t   mem_rdata;
  data_t   key_code;
  logic    key_valid;
  data_t   shadow;
  data_t   text_color;
  nibble_t border_color;

  logic [31:0] lfsr_state = 32'he9d;
  int          last_lat;
  int          check_count;
  int          err_count;
  int          case_err_start;
  int          case_count;
  int          case_fail;

  // memory model contents and the last access it served
  data_t       mem_store [logic [23:0]];
  logic [23:0] last_mem_full;
  logic        last_mem_we;
  data_t       last_mem_wdata;
  int          mem_count;

  iigs_io i_dut (
    .clk_sys      (clk_sys),
    .cpu_vda      (cpu_vda),
    .req          (req),
    .we           (we),
    .bank         (bank),
    .addr         (addr),
    .wdata        (wdata),
    .ack          (ack),
    .rdata        (rdata),
    .mem_req      (mem_req),
    .mem_we       (mem_we),
    .mem_bank     (mem_bank),
    .mem_addr     (mem_addr),
    .mem_wdata    (mem_wdata),
    .mem_ack      (mem_ack),
    .mem_rdata    (mem_rdata),
    .key_code     (key_code),
    .key_valid    (key_valid),
    .shadow       (shadow),
    .text_color   (text_color),
    .border_color (border_color)
  );

  initial begin
    clk_sys = 1'b0;
    forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
  end

  // 32-bit fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = 32'h0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  // unwritten memory returns a pattern of the full 24-bit address
  function automatic data_t fill_byte(input logic [23:0] a);
    return a[23:16] ^ a[15:8] ^ a[7:0] ^ 8'h5A;
  endfunction

  // memory side of the four-phase handshake, 0 to 3 cycles of delay
  initial begin
    int          delay;
    logic [23:0] full;
    mem_ack   = 1'b0;
    mem_rdata = 8'h00;
    mem_count = 0;
    forever begin
      @(posedge clk_sys);
      if (mem_req && !mem_ack) begin
        delay = lfsr_bits(2);
        repeat (delay) @(posedge clk_sys);
        full           = {mem_bank, mem_addr};
        last_mem_full  = full;
        last_mem_we    = mem_we;
        last_mem_wdata = mem_wdata;
        mem_count++;
        if (mem_we) begin
          mem_store[full] = mem_wdata;
        end else if (mem_store.exists(full)) begin
          mem_rdata <= mem_store[full];
        end else begin
          mem_rdata <= fill_byte(full);
        end
        mem_ack <= 1'b1;
      end else if (!mem_req && mem_ack) begin
        mem_ack <= 1'b0;
      end
    end
  end

  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("watchdog: simulation did not finish within %0d clock cycles", TIMEOUT_CYCLES);
    $display("Some tests failed");
    $finish;
  end

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("** Error: %s = 0x%0h, expected 0x%0h (time %0t)", name, got, exp, $time);
    end
  endtask

  task automatic start_case();
    case_err_start = err_count;
    case_count++;
  endtask

  task automatic report_case(input string name);
    if (err_count == case_err_start) begin
      $display("test %s: ok", name);
    end else begin
      case_fail++;
      $display("test %s: FAILED with %0d mismatches", name, err_count - case_err_start);
    end
  endtask

  task automatic apply_reset();
    @(posedge clk_sys);
    cpu_vda <= 1'b1;
    repeat (2) @(posedge clk_sys);
    cpu_vda <= 1'b0;
  endtask

  // one complete CPU transaction, latency counted from the drive edge
  task automatic bus_access(input bank_t b, input addr_t a, input logic w, input data_t d,
                            output data_t rd);
    logic seen;
    @(posedge clk_sys);
    req   <= 1'b1;
    we    <= w;
    bank  <= b;
    addr  <= a;
    wdata <= d;
    last_lat = 0;
    seen = 1'b0;
    while (!seen) begin
      @(posedge clk_sys);
      last_lat++;
      @(negedge clk_sys);
      seen = ack;
    end
    rd = rdata;
    @(posedge clk_sys);
    req <= 1'b0;
    do begin
      @(negedge clk_sys);
    end while (ack);
  endtask

  task automatic bus_write(input bank_t b, input addr_t a, input data_t d);
    data_t unused;
    bus_access(b, a, 1'b1, d, unused);
  endtask

  task automatic bus_read(input bank_t b, input addr_t a, output data_t rd);
    bus_access(b, a, 1'b0, 8'h00, rd);
  endtask

  task automatic press_key(input data_t code);
    @(posedge clk_sys);
    key_code  <= code;
    key_valid <= 1'b1;
    @(posedge clk_sys);
    key_valid <= 1'b0;
  endtask

  // polls the clock control register until busy drops
  task automatic wait_clock_idle(output int busy_reads);
    data_t st;
    busy_reads = 0;
    st = 8'h80;
    while (st[7]) begin
      bus_read(8'h00, 16'hC034, st);
      if (st[7]) begin
        busy_reads++;
      end
    end
  endtask

  task automatic reset_defaults();
    data_t rd;
    start_case();
    check("ack", 32'(ack), 32'h0);
    check("mem_req", 32'(mem_req), 32'h0);
    bus_read(8'h00, 16'hC035, rd);
    check("rdata C035", 32'(rd), 32'h08);
    bus_read(8'h00, 16'hC036, rd);
    check("rdata C036", 32'(rd), 32'h80);
    bus_read(8'h00, 16'hC068, rd);
    check("rdata C068", 32'(rd), 32'h09);
    check("shadow", 32'(shadow), 32'h08);
    report_case("reset values");
  endtask

  task automatic soft_switch_access();
    data_t rd;
    start_case();
    bus_write(8'h00, 16'hC022, 8'h5A);
    check("ack latency C022", 32'(last_lat), 32'd3);
    check("text_color", 32'(text_color), 32'h5A);
    // clock control register sits behind $C034, so one extra cycle
    bus_write(8'h00, 16'hC034, 8'h0B);
    check("ack latency C034", 32'(last_lat), 32'd4);
    check("border_color", 32'(border_color), 32'hB);
    bus_write(8'hE1, 16'hC068, 8'h46);
    bus_read(8'hE1, 16'hC068, rd);
    check("rdata C068", 32'(rd), 32'h47);
    check("ack latency C068", 32'(last_lat), 32'd3);
    report_case("soft switches");
  endtask

  task automatic memory_and_remap();
    data_t rd;
    int    count_before;
    start_case();
    bus_write(8'h02, 16'h1234, 8'hA5);
    check("mem addr", 32'(last_mem_full), 32'h021234);
    check("mem_we", 32'(last_mem_we), 32'h1);
    check("mem_wdata", 32'(last_mem_wdata), 32'hA5);
    bus_write(8'h02, 16'hC010, 8'h3C);
    check("mem addr", 32'(last_mem_full), 32'h02C010);
    bus_read(8'h02, 16'h1234, rd);
    check("rdata 02/1234", 32'(rd), 32'hA5);
    check("mem_we", 32'(last_mem_we), 32'h0);
    bus_read(8'h02, 16'hC010, rd);
    check("rdata 02/C010", 32'(rd), 32'h3C);
    // slot ROM select clear after reset
    bus_read(8'h00, 16'hC712, rd);
    check("mem addr remap", 32'(last_mem_full), 32'h00C512);
    check("rdata 00/C712", 32'(rd), 32'(fill_byte(24'h00C512)));
    count_before = mem_count;
    bus_write(8'h00, 16'hC02D, 8'h80);
    check("mem accesses on I/O write", 32'(mem_count), 32'(count_before));
    bus_read(8'h00, 16'hC712, rd);
    check("mem addr no remap", 32'(last_mem_full), 32'h00C712);
    bus_write(8'h00, 16'hC035, 8'h48);
    check("shadow", 32'(shadow), 32'h48);
    count_before = mem_count;
    bus_read(8'h00, 16'hC036, rd);
    check("mem accesses with I/O off", 32'(mem_count), 32'(count_before + 1));
    check("mem addr I/O off", 32'(last_mem_full), 32'h00C036);
    check("rdata 00/C036", 32'(rd), 32'(fill_byte(24'h00C036)));
    // the I/O page can no longer reach $C035, reset brings it back
    apply_reset();
    report_case("memory and remap");
  endtask

  task automatic keyboard_adb();
    data_t rd;
    start_case();
    press_key(8'h41);
    bus_read(8'h00, 16'hC000, rd);
    check("rdata C000", 32'(rd), 32'hC1);
    bus_read(8'h00, 16'hC027, rd);
    check("rdata C027", 32'(rd), 32'h80);
    bus_read(8'h00, 16'hC010, rd);
    bus_read(8'h00, 16'hC000, rd);
    check("rdata C000 after strobe", 32'(rd), 32'h41);
    bus_write(8'h00, 16'hC026, 8'h0D);
    bus_read(8'h00, 16'hC027, rd);
    check("rdata C027 pending", 32'(rd), 32'h01);
    bus_read(8'h00, 16'hC026, rd);
    check("rdata C026", 32'(rd), 32'h06);
    bus_read(8'h00, 16'hC027, rd);
    check("rdata C027 after read", 32'(rd), 32'h00);
    report_case("keyboard adb");
  endtask

  task automatic battery_ram();
    data_t       rd;
    data_t       expect_q [$];
    logic [31:0] rnd;
    int          busy_reads;
    start_case();
    bus_write(8'h00, 16'hC033, 8'h40);
    bus_write(8'h00, 16'hC034, 8'hA0);
    wait_clock_idle(busy_reads);
    check("clock busy after start", 32'(busy_reads != 0), 32'h1);
    for (int i = 0; i < 6; i++) begin
      rnd = lfsr_bits(8);
      expect_q.push_back(rnd[7:0]);
      bus_write(8'h00, 16'hC033, rnd[7:0]);
      bus_write(8'h00, 16'hC034, 8'h80);
      wait_clock_idle(busy_reads);
    end
    bus_write(8'h00, 16'hC033, 8'h40);
    bus_write(8'h00, 16'hC034, 8'hA0);
    wait_clock_idle(busy_reads);
    for (int i = 0; i < 6; i++) begin
      bus_write(8'h00, 16'hC034, 8'hC0);
      wait_clock_idle(busy_reads);
      bus_read(8'h00, 16'hC033, rd);
      check($sformatf("battery ram byte %0d", i), 32'(rd), 32'(expect_q[i]));
    end
    report_case("battery ram");
  endtask

  initial begin
    cpu_vda   = 1'b1;
    req       = 1'b0;
    we        = 1'b0;
    bank      = 8'h00;
    addr      = 16'h0000;
    wdata     = 8'h00;
    key_code  = 8'h00;
    key_valid = 1'b0;
    check_count = 0;
    err_count   = 0;
    case_count  = 0;
    case_fail   = 0;
    repeat (2) @(posedge clk_sys);
    cpu_vda <= 1'b0;
    reset_defaults();
    soft_switch_access();
    memory_and_remap();
    keyboard_adb();
    battery_ram();
    $display("summary: %0d tests, %0d failing, %0d checks, %0d mismatches",
             case_count, case_fail, check_count, err_count);
    if (err_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* hdl/iigs_io.sv */
`timescale 1ns/1ps

module iigs_io
  import iigs_bus_pkg::*;
  import iigs_dev_pkg::*;
(
  input  logic    clk_sys,
  input  logic    cpu_vda,
  input  logic    req,
  input  logic    we,
  input  bank_t   bank,
  input  addr_t   addr,
  input  data_t   wdata,
  output logic    ack,
  output data_t   rdata,
  output logic    mem_req,
  output logic    mem_we,
  output bank_t   mem_bank,
  output addr_t   mem_addr,
  output data_t   mem_wdata,
  input  logic    mem_ack,
  input  data_t   mem_rdata,
  input  data_t   key_code,
  input  logic    key_valid,
  output data_t   shadow,
  output data_t   text_color,
  output nibble_t border_color
);

  logic    io_start;
  logic    io_we;
  io_reg_t io_reg;
  data_t   io_wdata;
  logic    io_done;
  data_t   io_rdata;
  logic    slot_rom_sel;

  logic    adb_strobe;
  logic    adb_rw;
  io_reg_t adb_addr;
  data_t   adb_din;
  data_t   adb_dout;

  logic    clk_strobe;
  logic    clk_rw;
  logic    clk_sel;
  data_t   clk_din;
  data_t   clk_dout;

  bus_port i_bus_port (
    .clk_sys       (clk_sys),
    .cpu_vda       (cpu_vda),
    .req           (req),
    .we            (we),
    .bank          (bank),
    .addr          (addr),
    .wdata         (wdata),
    .ack           (ack),
    .rdata         (rdata),
    .mem_req       (mem_req),
    .mem_we        (mem_we),
    .mem_bank      (mem_bank),
    .mem_addr      (mem_addr),
    .mem_wdata     (mem_wdata),
    .mem_ack       (mem_ack),
    .mem_rdata     (mem_rdata),
    .io_start      (io_start),
    .io_we         (io_we),
    .io_reg        (io_reg),
    .io_wdata      (io_wdata),
    .io_done       (io_done),
    .io_rdata      (io_rdata),
    // shadow bit 6 turns the I/O page into plain memory
    .io_shadow_off (shadow[6]),
    .slot_rom_sel  (slot_rom_sel)
  );

  io_regs i_io_regs (
    .clk_sys      (clk_sys),
    .cpu_vda      (cpu_vda),
    .io_start     (io_start),
    .io_we        (io_we),
    .io_reg       (io_reg),
    .io_wdata     (io_wdata),
    .io_done      (io_done),
    .io_rdata     (io_rdata),
    .adb_strobe   (adb_strobe),
    .adb_rw       (adb_rw),
    .adb_addr     (adb_addr),
    .adb_din      (adb_din),
    .adb_dout     (adb_dout),
    .clk_strobe   (clk_strobe),
    .clk_rw       (clk_rw),
    .clk_sel      (clk_sel),
    .clk_din      (clk_din),
    .clk_dout     (clk_dout),
    .shadow       (shadow),
    .text_color   (text_color),
    .border_color (border_color),
    .slot_rom_sel (slot_rom_sel)
  );

  adb_glu i_adb_glu (
    .clk_sys   (clk_sys),
    .cpu_vda   (cpu_vda),
    .strobe    (adb_strobe),
    .rw        (adb_rw),
    .addr      (adb_addr),
    .din       (adb_din),
    .dout      (adb_dout),
    .key_code  (key_code),
    .key_valid (key_valid)
  );

  prtc i_prtc (
    .clk_sys (clk_sys),
    .cpu_vda (cpu_vda),
    .strobe  (clk_strobe),
    .rw      (clk_rw),
    .sel     (clk_sel),
    .din     (clk_din),
    .dout    (clk_dout)
  );

endmodule

/* hdl/prtc.sv */
`timescale 1ns/1ps
`include "iigs_consts.svh"

module prtc
  import iigs_bus_pkg::*;
(
  input  logic  clk_sys,
  input  logic  cpu_vda,
  input  logic  strobe,
  input  logic  rw,
  input  logic  sel,
  input  data_t din,
  output data_t dout
);

  // battery RAM
  data_t ram [0:255];

  data_t      data_reg;
  logic [7:0] ram_addr;
  logic [6:0] ctl_low;
  logic [3:0] busy_cnt;

  logic busy;
  logic ctl_start;
  logic do_addr;
  logic do_read;
  logic do_write;

  assign busy      = (busy_cnt != 4'd0);
  assign ctl_start = strobe && !rw && sel && din[7];
  assign do_addr   = ctl_start && din[5];
  assign do_read   = ctl_start && !din[5] && din[6];
  assign do_write  = ctl_start && !din[5] && !din[6];

  always_ff @(posedge clk_sys or posedge cpu_vda) begin
    if (cpu_vda) begin
      ram_addr <= 8'h00;
      ctl_low  <= 7'h00;
      busy_cnt <= 4'd0;
    end else begin
      if (ctl_start) begin
        busy_cnt <= 4'(`CLK_BUSY_CYCLES);
      end else if (busy) begin
        busy_cnt <= busy_cnt - 4'd1;
      end
      if (strobe && !rw && sel) begin
        ctl_low <= din[6:0];
      end
      // address phase loads the pointer, data phases step it
      if (do_addr) begin
        ram_addr <= data_reg;
      end else if (do_read || do_write) begin
        ram_addr <= ram_addr + 8'd1;
      end
    end
  end

  always_ff @(posedge clk_sys) begin
    if (do_write) begin
      ram[ram_addr] <= data_reg;
    end
    if (strobe && !rw && !sel) begin
      data_reg <= din;
    end else if (do_read) begin
      data_reg <= ram[ram_addr];
    end
    if (strobe && rw) begin
      dout <= sel ? {busy, ctl_low} : data_reg;
    end
  end

endmodule

/* hdl/adb_glu.sv */
`timescale 1ns/1ps
`include "iigs_consts.svh"

module adb_glu
  import iigs_bus_pkg::*;
  import iigs_dev_pkg::*;
(
  input  logic    clk_sys,
  input  logic    cpu_vda,
  input  logic    strobe,
  input  logic    rw,
  input  io_reg_t addr,
  input  data_t   din,
  output data_t   dout,
  input  data_t   key_code,
  input  logic    key_valid
);

  data_t key_latch;
  data_t adb_cmd;
  logic  resp_pending;
  data_t cmd_resp;

  // only the version query has an answer in this model
  assign cmd_resp = (adb_cmd == `ADB_VERSION_CMD) ? `ADB_VERSION : 8'h00;

  always_ff @(posedge clk_sys or posedge cpu_vda) begin
    if (cpu_vda) begin
      key_latch    <= 8'h00;
      adb_cmd      <= 8'h00;
      resp_pending <= 1'b0;
    end else begin
      // any access to the strobe clears the key flag
      if (strobe && addr == `IO_KBDSTRB) begin
        key_latch[7] <= 1'b0;
      end
      // a new key wins over a strobe in the same cycle
      if (key_valid) begin
        key_latch <= {1'b1, key_code[6:0]};
      end
      if (strobe && addr == `IO_ADBCMD) begin
        if (!rw) begin
          adb_cmd      <= din;
          resp_pending <= 1'b1;
        end else begin
          resp_pending <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_sys) begin
    if (strobe && rw) begin
      case (addr)
        `IO_KBD, `IO_KBDSTRB: dout <= key_latch;
        `IO_ADBCMD:           dout <= cmd_resp;
        `IO_ADBSTAT:          dout <= {key_latch[7], 6'b000000, resp_pending};
        default:              dout <= 8'h00;
      endcase
    end
  end

endmodule

/* hdl/io_regs.sv */
`timescale 1ns/1ps
`include "iigs_consts.svh"

module io_regs
  import iigs_bus_pkg::*;
  import iigs_dev_pkg::*;
(
  input  logic    clk_sys,
  input  logic    cpu_vda,
  input  logic    io_start,
  input  logic    io_we,
  input  io_reg_t io_reg,
  input  data_t   io_wdata,
  output logic    io_done,
  output data_t   io_rdata,
  output logic    adb_strobe,
  output logic    adb_rw,
  output io_reg_t adb_addr,
  output data_t   adb_din,
  input  data_t   adb_dout,
  output logic    clk_strobe,
  output logic    clk_rw,
  output logic    clk_sel,
  output data_t   clk_din,
  input  data_t   clk_dout,
  output data_t   shadow,
  output data_t   text_color,
  output nibble_t border_color,
  output logic    slot_rom_sel
);

  regs_state_t state;
  dev_sel_t    src;

  data_t sltromsel;
  data_t cyareg;
  data_t statereg;
  data_t newvideo;
  data_t sound_ctl;
  data_t sound_data;
  data_t sound_adrl;
  data_t sound_adrh;

  data_t loc_rdata;
  data_t dev_din;
  logic  dev_rw;
  logic  is_adb;
  logic  is_clk;

  always_comb begin
    is_adb = 1'b0;
    is_clk = 1'b0;
    case (io_reg)
      `IO_KBD, `IO_KBDSTRB, `IO_ADBCMD, `IO_ADBSTAT: is_adb = 1'b1;
      `IO_CLKDATA, `IO_CLKCTL: is_clk = 1'b1;
      default: ;
    endcase
  end

  always_ff @(posedge clk_sys or posedge cpu_vda) begin
    if (cpu_vda) begin
      state        <= regs_idle;
      src          <= sel_none;
      shadow       <= `SHADOW_RST;
      cyareg       <= `CYAREG_RST;
      statereg     <= `STATEREG_RST;
      text_color   <= 8'h00;
      border_color <= 4'h0;
      sltromsel    <= 8'h00;
      newvideo     <= 8'h00;
      sound_ctl    <= 8'h00;
      sound_data   <= 8'h00;
      sound_adrl   <= 8'h00;
      sound_adrh   <= 8'h00;
    end else begin
      case (state)
        regs_idle: begin
          if (io_start) begin
            if (is_adb) begin
              src   <= sel_adb;
              state <= regs_dev_wait;
            end else if (is_clk) begin
              src   <= sel_clk;
              state <= regs_dev_wait;
            end else begin
              src   <= sel_none;
              state <= regs_done;
            end
            if (io_we) begin
              case (io_reg)
                `IO_TEXTCOLOR: text_color <= io_wdata;
                `IO_NEWVIDEO:  newvideo   <= io_wdata;
                `IO_SLTROMSEL: sltromsel  <= io_wdata;
                // border color shares $C034 with the clock control register
                `IO_CLKCTL:    border_color <= io_wdata[3:0];
                `IO_SHADOW:    shadow     <= io_wdata;
                `IO_CYAREG:    cyareg     <= io_wdata;
                `IO_SOUNDCTL:  sound_ctl  <= io_wdata;
                `IO_SOUNDDATA: sound_data <= io_wdata;
                `IO_SOUNDADRL: sound_adrl <= io_wdata;
                `IO_SOUNDADRH: sound_adrh <= io_wdata;
                // internal ROM select in bit 0 is always on
                `IO_STATEREG:  statereg   <= {io_wdata[7:1], 1'b1};
                default: ;
              endcase
            end
          end
        end
        // device registers its dout during this cycle
        regs_dev_wait: state <= regs_done;
        regs_done:     state <= regs_idle;
        default:       state <= regs_idle;
      endcase
    end
  end

  always_ff @(posedge clk_sys) begin
    if (state == regs_idle && io_start) begin
      adb_addr <= io_reg;
      dev_din  <= io_wdata;
      dev_rw   <= !io_we;
      clk_sel  <= (io_reg == `IO_CLKCTL);
      case (io_reg)
        `IO_TEXTCOLOR: loc_rdata <= text_color;
        `IO_NEWVIDEO:  loc_rdata <= newvideo;
        `IO_SLTROMSEL: loc_rdata <= sltromsel;
        `IO_SHADOW:    loc_rdata <= shadow;
        `IO_CYAREG:    loc_rdata <= cyareg;
        `IO_SOUNDCTL:  loc_rdata <= sound_ctl;
        `IO_SOUNDDATA: loc_rdata <= sound_data;
        `IO_SOUNDADRL: loc_rdata <= sound_adrl;
        `IO_SOUNDADRH: loc_rdata <= sound_adrh;
        `IO_STATEREG:  loc_rdata <= statereg;
        default:       loc_rdata <= 8'h00;
      endcase
    end
  end

  always_comb begin
    case (src)
      sel_adb: io_rdata = adb_dout;
      sel_clk: io_rdata = clk_dout;
      default: io_rdata = loc_rdata;
    endcase
  end

  assign io_done    = (state == regs_done);
  assign adb_strobe = (state == regs_dev_wait) && (src == sel_adb);
  assign clk_strobe = (state == regs_dev_wait) && (src == sel_clk);

  // device rw is high for a read
  assign adb_rw  = dev_rw;
  assign clk_rw  = dev_rw;
  assign adb_din = dev_din;
  assign clk_din = dev_din;

  assign slot_rom_sel = sltromsel[7];

endmodule

/* hdl/bus_port.sv */
`timescale 1ns/1ps
`include "iigs_consts.svh"

module bus_port
  import iigs_bus_pkg::*;
  import iigs_dev_pkg::*;
(
  input  logic    clk_sys,
  input  logic    cpu_vda,
  input  logic    req,
  input  logic    we,
  input  bank_t   bank,
  input  addr_t   addr,
  input  data_t   wdata,
  output logic    ack,
  output data_t   rdata,
  output logic    mem_req,
  output logic    mem_we,
  output bank_t   mem_bank,
  output addr_t   mem_addr,
  output data_t   mem_wdata,
  input  logic    mem_ack,
  input  data_t   mem_rdata,
  output logic    io_start,
  output logic    io_we,
  output io_reg_t io_reg,
  output data_t   io_wdata,
  input  logic    io_done,
  input  data_t   io_rdata,
  input  logic    io_shadow_off,
  input  logic    slot_rom_sel
);

  port_state_t state;

  bank_t lat_bank;
  addr_t lat_addr;
  logic  lat_we;
  data_t lat_wdata;

  addr_t remap_addr;
  logic  is_io;

  // slot ROM at $C7xx shows up as $C5xx unless the select bit is set
  always_comb begin
    remap_addr = addr;
    if (addr[15:8] == `SLOT_ROM_PAGE) begin
      remap_addr[9] = slot_rom_sel;
    end
  end

  // I/O page only exists in the fast banks and the two mega II banks
  assign is_io = !io_shadow_off &&
                 (remap_addr[15:8] == `IO_PAGE) &&
                 (bank inside {8'h00, 8'h01, 8'hE0, 8'hE1});

  // request is held for the whole access, both sides read it from here
  always_ff @(posedge clk_sys) begin
    if (state == port_idle && req) begin
      lat_bank  <= bank;
      lat_addr  <= remap_addr;
      lat_we    <= we;
      lat_wdata <= wdata;
    end
  end

  always_ff @(posedge clk_sys) begin
    if (state == port_io_wait && io_done) begin
      rdata <= io_rdata;
    end else if (state == port_mem_wait && mem_ack) begin
      rdata <= mem_rdata;
    end
  end

  always_ff @(posedge clk_sys or posedge cpu_vda) begin
    if (cpu_vda) begin
      state    <= port_idle;
      ack      <= 1'b0;
      mem_req  <= 1'b0;
      io_start <= 1'b0;
    end else begin
      io_start <= 1'b0;
      case (state)
        port_idle: begin
          if (req) begin
            if (is_io) begin
              io_start <= 1'b1;
              state    <= port_io_wait;
            end else begin
              mem_req <= 1'b1;
              state   <= port_mem_wait;
            end
          end
        end
        port_io_wait: begin
          if (io_done) begin
            ack   <= 1'b1;
            state <= port_ack_hold;
          end
        end
        port_mem_wait: begin
          if (mem_ack) begin
            mem_req <= 1'b0;
            ack     <= 1'b1;
            state   <= port_ack_hold;
          end
        end
        port_ack_hold: begin
          // both masters must have released before the next access
          if (!req && !mem_ack) begin
            ack   <= 1'b0;
            state <= port_idle;
          end
        end
        default: state <= port_idle;
      endcase
    end
  end

  assign mem_bank  = lat_bank;
  assign mem_addr  = lat_addr;
  assign mem_we    = lat_we;
  assign mem_wdata = lat_wdata;

  assign io_reg   = lat_addr[7:0];
  assign io_we    = lat_we;
  assign io_wdata = lat_wdata;

endmodule

/* hdl/iigs_dev_pkg.sv */
package iigs_dev_pkg;

  // register offset inside the $C0xx I/O page
  typedef logic [7:0] io_reg_t;

  // 4-bit color index, border color uses it
  typedef logic [3:0] nibble_t;

  // bus_port handshake sequencer
  typedef enum logic [1:0] {
    port_idle,
    port_io_wait,
    port_mem_wait,
    port_ack_hold
  } port_state_t;

  // io_regs access sequencer
  typedef enum logic [1:0] {
    regs_idle,
    regs_dev_wait,
    regs_done
  } regs_state_t;

  // which block supplies the read byte of the current access
  typedef enum logic [1:0] {
    sel_none,
    sel_adb,
    sel_clk
  } dev_sel_t;

endpackage

/* hdl/iigs_bus_pkg.sv */
package iigs_bus_pkg;

  // 65C816 address is bank:addr, 24 bits in total
  typedef logic [7:0]  bank_t;
  typedef logic [15:0] addr_t;

  // one byte on the data bus
  typedef logic [7:0]  data_t;

endpackage

/* hdl/iigs_consts.svh */
`ifndef IIGS_CONSTS_SVH
`define IIGS_CONSTS_SVH

// offsets within page $C0
`define IO_KBD          8'h00
`define IO_KBDSTRB      8'h10
`define IO_TEXTCOLOR    8'h22
`define IO_ADBCMD       8'h26
`define IO_ADBSTAT      8'h27
`define IO_NEWVIDEO     8'h29
`define IO_SLTROMSEL    8'h2D
`define IO_CLKDATA      8'h33
`define IO_CLKCTL       8'h34
`define IO_SHADOW       8'h35
`define IO_CYAREG       8'h36
`define IO_SOUNDCTL     8'h3C
`define IO_SOUNDDATA    8'h3D
`define IO_SOUNDADRL    8'h3E
`define IO_SOUNDADRH    8'h3F
`define IO_STATEREG     8'h68

// address pages seen by the decoder
`define IO_PAGE         8'hC0
`define SLOT_ROM_PAGE   8'hC7

// soft switch values after reset
`define SHADOW_RST      8'h08
`define CYAREG_RST      8'h80
`define STATEREG_RST    8'h09

// keyboard micro firmware version query
`define ADB_VERSION_CMD 8'h0D
`define ADB_VERSION     8'h06

// clock chip busy time per transaction, in clk_sys cycles
`define CLK_BUSY_CYCLES 8

`endif
